// ==== emesh_pkg.sv ====
`default_nettype none

package emesh_pkg;

   //########################################
   //# Packet and field widths
   //########################################
   localparam int PKT_W  = 104;          // Full emesh packet
   localparam int ADDR_W = 32;           // Emesh address
   localparam int DATA_W = 32;           // Emesh data

   typedef logic [ADDR_W-1:0] addr_t;    // Address field
   typedef logic [DATA_W-1:0] data_t;    // Data field
   typedef logic [1:0]        mode_t;    // Access size
   typedef logic [4:0]        ctrl_t;    // Control mode, passed through

   // Data mode encodings
   localparam mode_t MODE_BYTE   = 2'd0;
   localparam mode_t MODE_HALF   = 2'd1;
   localparam mode_t MODE_WORD   = 2'd2;
   localparam mode_t MODE_DOUBLE = 2'd3; // Served as a word

   // Emesh bit order, MSB first
   typedef struct packed {
      addr_t srcaddr;                    // Where a response goes
      data_t data;                       // Write data or read payload
      addr_t dstaddr;                    // Target address
      ctrl_t ctrlmode;
      mode_t datamode;
      logic  write;                      // 1 for write or read response
   } packet_t;

   //########################################
   //# Memory target
   //########################################
   localparam logic [11:0] MEM_CHIP_ID = 12'h820; // Matched against dstaddr[31:20]
   localparam int          MEM_DEPTH   = 64;      // Words
   localparam int          IDX_W       = $clog2(MEM_DEPTH);

   typedef logic [IDX_W-1:0]    word_idx_t; // dstaddr[7:2]
   typedef logic [1:0]          lane_t;     // dstaddr[1:0]
   typedef logic [DATA_W/8-1:0] strb_t;     // One bit per byte

   // Request after decode and window filter
   typedef struct packed {
      logic      write;
      mode_t     datamode;
      ctrl_t     ctrlmode;
      word_idx_t idx;                    // Word in memory
      lane_t     lane;                   // Byte offset inside word
      data_t     data;
      addr_t     srcaddr;                // Return address for reads
   } mem_req_t;

endpackage

`default_nettype wire

// ==== emesh_word_ram.sv ====
`default_nettype none

module emesh_word_ram (
   input  logic                 clk,
   input  logic                 wr_en,
   input  emesh_pkg::word_idx_t wr_idx,
   input  emesh_pkg::strb_t     wr_strb,
   input  emesh_pkg::data_t     wr_data,
   input  logic                 rd_en,
   input  emesh_pkg::word_idx_t rd_idx,
   output emesh_pkg::data_t     rd_data
);
   import emesh_pkg::*;

   data_t mem [MEM_DEPTH];               // Storage, contents undefined at start

   //########################################
   //# Write port
   //########################################
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (wr_strb[b]) begin
               mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8]; // Masked byte
            end
         end
      end
   end

   //########################################
   //# Read port
   //########################################
   // Registered, holds last word between reads
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

// ==== emesh_ingress.sv ====
`default_nettype none

module emesh_ingress (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                access_in,
   input  emesh_pkg::packet_t  packet_in,
   output logic                wait_out,
   output logic                req_access,
   output emesh_pkg::mem_req_t req,
   input  logic                req_wait
);
   import emesh_pkg::*;

   logic     full;                       // Entry holds a request
   logic     accept;                     // Packet taken at this edge
   logic     hit;                        // Inside our chip-ID window
   logic     load;                       // Accepted and kept
   mem_req_t dec;                        // packet_in in request form

   //########################################
   //# Decode and window filter
   //########################################
   assign hit = (packet_in.dstaddr[31:20] == MEM_CHIP_ID);

   always_comb begin
      dec.write    = packet_in.write;
      dec.datamode = packet_in.datamode;
      dec.ctrlmode = packet_in.ctrlmode;
      dec.idx      = packet_in.dstaddr[7:2];   // Upper address bits alias
      dec.lane     = packet_in.dstaddr[1:0];
      dec.data     = packet_in.data;
      dec.srcaddr  = packet_in.srcaddr;
   end

   //########################################
   //# Handshake
   //########################################
   assign wait_out   = full & req_wait;        // Stalled only when stuck
   assign accept     = access_in & ~wait_out;
   assign load       = accept & hit;           // Misses are swallowed here
   assign req_access = full;

   // Refill on the same edge the old item leaves
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full <= 1'b0;
      end else begin
         full <= load | wait_out;              // Stay full while downstream waits
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         req <= dec;                           // Payload, no reset
      end
   end

   // Downstream may sample req at any edge while it waits
   a_req_hold : assert property (@(posedge clk) disable iff (!arst_n)
      req_access && req_wait |=> req_access && $stable(req));

endmodule

`default_nettype wire

// ==== emesh_mem_stage.sv ====
`default_nettype none

module emesh_mem_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req_access,
   input  emesh_pkg::mem_req_t req,
   output logic                req_wait,
   output logic                access_out,
   output emesh_pkg::packet_t  packet_out,
   input  logic                wait_in
);
   import emesh_pkg::*;

   logic      xfer;                      // Request moves in this edge
   logic      wr_en;
   logic      rd_en;
   strb_t     wr_strb;
   data_t     wr_data;
   data_t     rd_data;                   // Raw word from RAM
   lane_t     rd_lane;                   // Aligned lane of held response
   data_t     rd_shift;
   data_t     rd_mask;
   addr_t     rsp_dst;                   // Response header
   word_idx_t rsp_idx;
   lane_t     rsp_lane;
   ctrl_t     rsp_ctrl;
   mode_t     rsp_mode;

   // Lane rounded down to the access size
   function automatic lane_t size_lane(mode_t mode, lane_t lane);
      case (mode)
         MODE_BYTE: return lane;
         MODE_HALF: return {lane[1], 1'b0};
         default:   return 2'd0;         // Word and double
      endcase
   endfunction

   //########################################
   //# Flow control
   //########################################
   // Only reads need the response register
   assign req_wait = access_out & wait_in & req_access & ~req.write;
   assign xfer     = req_access & ~req_wait;
   assign wr_en    = xfer & req.write;
   assign rd_en    = xfer & ~req.write;

   //########################################
   //# Write path
   //########################################
   always_comb begin
      wr_strb = 4'b1111;                 // Word by default
      wr_data = req.data;
      case (req.datamode)
         MODE_BYTE: begin
            wr_strb = 4'b0001 << req.lane;
            wr_data = {4{req.data[7:0]}};          // Byte in every lane
         end
         MODE_HALF: begin
            wr_strb = 4'b0011 << size_lane(MODE_HALF, req.lane);
            wr_data = {2{req.data[15:0]}};
         end
         MODE_WORD, MODE_DOUBLE: begin
            wr_strb = 4'b1111;
            wr_data = req.data;
         end
      endcase
   end

   emesh_word_ram u_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_idx  (req.idx),
      .wr_strb (wr_strb),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_idx  (req.idx),
      .rd_data (rd_data)
   );

   //########################################
   //# Read response
   //########################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         access_out <= 1'b0;
      end else begin
         access_out <= rd_en | (access_out & wait_in); // Load or hold
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rsp_dst  <= req.srcaddr;        // Back to the requester
         rsp_idx  <= req.idx;
         rsp_lane <= req.lane;
         rsp_ctrl <= req.ctrlmode;
         rsp_mode <= req.datamode;
      end
   end

   assign rd_lane  = size_lane(rsp_mode, rsp_lane);
   assign rd_shift = rd_data >> {rd_lane, 3'b000};  // Right-align selected bytes
   assign rd_mask  = (rsp_mode == MODE_BYTE) ? 32'h0000_00ff :
                     (rsp_mode == MODE_HALF) ? 32'h0000_ffff : 32'hffff_ffff;

   always_comb begin
      packet_out.srcaddr  = {MEM_CHIP_ID, 12'h000, rsp_idx, rsp_lane}; // Rebuilt target
      packet_out.data     = rd_shift & rd_mask;   // Zero-extended
      packet_out.dstaddr  = rsp_dst;
      packet_out.ctrlmode = rsp_ctrl;
      packet_out.datamode = rsp_mode;
      packet_out.write    = 1'b1;                 // Responses travel as writes
   end

   // Held response needs header and RAM output both frozen
   a_rsp_hold : assert property (@(posedge clk) disable iff (!arst_n)
      access_out && wait_in |=> access_out && $stable(packet_out));

endmodule

`default_nettype wire

// ==== emesh_mem_top.sv ====
`default_nettype none

module emesh_mem_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in
);
   import emesh_pkg::*;

   logic     req_access;                 // Ingress to memory stage
   mem_req_t req;
   logic     req_wait;                   // Back-pressure from memory stage

   //########################################
   //# Stage 1, decode and filter
   //########################################
   emesh_ingress u_ingress (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .req_access (req_access),
      .req        (req),
      .req_wait   (req_wait)
   );

   //########################################
   //# Stage 2, memory and response
   //########################################
   emesh_mem_stage u_mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_access (req_access),
      .req        (req),
      .req_wait   (req_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

endmodule

`default_nettype wire

// ==== tb_emesh_mem.sv ====
`default_nettype none

module tb_emesh_mem;
   import emesh_pkg::*;

   logic    clk;
   logic    arst_n;
   logic    access_in;
   packet_t packet_in;
   logic    wait_out;
   logic    access_out;
   packet_t packet_out;
   logic    wait_in;

   logic [7:0] op_q [$];                 // 'W' or 'R'
   addr_t      dst_q [$];
   addr_t      src_q [$];
   data_t      dat_q [$];
   mode_t      mode_q [$];
   data_t      rdexp_q [$];              // Expected read payload
   packet_t    exp_q [$];                // Responses still owed by the DUT
   int         n_items = 0;

   emesh_mem_top uut (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic load_patterns();
      int         fd;
      int         code;
      string      line;
      logic [7:0] op;
      addr_t      dst;
      addr_t      src;
      data_t      dat;
      mode_t      mode;
      data_t      rdexp;
      fd = $fopen("emesh_patterns.txt", "r");
      if (fd == 0) abort_run("Cannot open emesh_patterns.txt");
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 0 && line.len() > 1 && line[0] != "#") begin // Skip blanks and notes
            code = $sscanf(line, "%c %h %h %h %d %h", op, dst, src, dat, mode, rdexp);
            if (code != 6) begin
               abort_run({"Malformed pattern line: ", line});
            end else begin
               op_q.push_back(op);
               dst_q.push_back(dst);
               src_q.push_back(src);
               dat_q.push_back(dat);
               mode_q.push_back(mode);
               rdexp_q.push_back(rdexp);
            end
         end
      end
      $fclose(fd);
      if (op_q.size() == 0) abort_run("Pattern file holds no transactions");
      n_items = op_q.size();
   endtask

   //########################################
   //# Clock, random wait, watchdog
   //########################################
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;            // Period 40
   end

   initial begin : wait_gen
      logic [31:0] rs;
      rs      = 32'd44;                  // Seed
      wait_in = 1'b0;
      @(posedge arst_n);
      forever begin
         @(posedge clk);
         rs = xorshift32(rs);
         wait_in <= (rs[2:0] < 3'd3);    // Busy about 3 cycles in 8
      end
   end

   initial begin : watchdog
      wait (n_items > 0);
      #(n_items * 30 * 40);
      abort_run("Watchdog expired before the run finished");
   end

   //########################################
   //# Response monitor
   //########################################
   initial begin : monitor
      packet_t exp;
      forever begin
         @(negedge clk);                 // Outputs settled, decides next edge
         if (arst_n && access_out && !wait_in) begin
            if (exp_q.size() == 0) begin
               abort_run("Read response arrived with no read outstanding");
            end else begin
               exp = exp_q.pop_front();
               check_value("packet_out.write", {31'd0, packet_out.write}, {31'd0, exp.write});
               check_value("packet_out.dstaddr", packet_out.dstaddr, exp.dstaddr);
               check_value("packet_out.srcaddr", packet_out.srcaddr, exp.srcaddr);
               check_value("packet_out.data", packet_out.data, exp.data);
               check_value("packet_out.ctrlmode", {27'd0, packet_out.ctrlmode},
                           {27'd0, exp.ctrlmode});
               check_value("packet_out.datamode", {30'd0, packet_out.datamode},
                           {30'd0, exp.datamode});
            end
         end
      end
   end

   //########################################
   //# Reset and request driver
   //########################################
   initial begin : driver
      packet_t pkt;
      packet_t rsp;
      logic    stalled;
      arst_n    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      load_patterns();
      repeat (4) begin
         @(negedge clk);
         check_value("access_out", {31'd0, access_out}, 32'd0); // Quiet in reset
         check_value("wait_out", {31'd0, wait_out}, 32'd0);
      end
      @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("access_out", {31'd0, access_out}, 32'd0);    // Still quiet after release
      check_value("wait_out", {31'd0, wait_out}, 32'd0);
      @(posedge clk);
      for (int i = 0; i < n_items; i++) begin
         pkt.srcaddr  = src_q[i];
         pkt.data     = dat_q[i];
         pkt.dstaddr  = dst_q[i];
         pkt.ctrlmode = i[4:0];          // Arbitrary tag, must echo back
         pkt.datamode = mode_q[i];
         pkt.write    = (op_q[i] == "W");
         access_in <= 1'b1;
         packet_in <= pkt;
         if (op_q[i] == "R" && dst_q[i][31:20] == MEM_CHIP_ID) begin
            rsp.write    = 1'b1;         // Responses are writes
            rsp.dstaddr  = src_q[i];
            rsp.srcaddr  = {MEM_CHIP_ID, 12'h000, dst_q[i][7:0]};
            rsp.data     = rdexp_q[i];
            rsp.ctrlmode = i[4:0];
            rsp.datamode = mode_q[i];
            exp_q.push_back(rsp);
         end
         do begin
            @(negedge clk);
            stalled = wait_out;          // Held through this edge?
            @(posedge clk);
         end while (stalled);
      end
      access_in <= 1'b0;
      for (int k = 0; k < 200 && exp_q.size() != 0; k++) begin
         @(posedge clk);
      end
      repeat (8) @(posedge clk);         // Room for a stray response
      if (exp_q.size() == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         abort_run("Some expected read responses never arrived");
      end
   end

endmodule

`default_nettype wire

// ==== emesh_patterns.txt ====
# op dstaddr srcaddr data datamode expected_read_data
# Hex fields except datamode (0 byte, 1 half, 2 word, 3 double); W lines ignore the last column
W 82000010 00000000 deadbeef 2 00000000
R 82000010 0000a001 00000000 2 deadbeef
W 82000014 00000000 00000000 2 00000000
W 82000014 00000000 000000aa 0 00000000
W 82000015 00000000 000000bb 0 00000000
W 82000016 00000000 0000ccdd 1 00000000
R 82000014 0000a002 00000000 2 ccddbbaa
R 82000015 0000a003 00000000 0 000000bb
R 82000017 0000a004 00000000 0 000000cc
R 82000016 0000a005 00000000 1 0000ccdd
R 82000017 0000a006 00000000 1 0000ccdd
R 82000014 0000a007 00000000 1 0000bbaa
W 82000020 00000000 12345678 3 00000000
R 82000020 0000a008 00000000 3 12345678
W 81000010 00000000 55555555 2 00000000
W 82100010 00000000 66666666 2 00000000
R 81000010 0000a009 00000000 2 00000000
R 82000010 0000a00a 00000000 2 deadbeef
R 82000110 0000a00b 00000000 2 deadbeef
W 82000040 00000000 11111111 2 00000000
W 82000044 00000000 22222222 2 00000000
R 82000040 0000a00c 00000000 2 11111111
W 82000048 00000000 33333333 2 00000000
R 82000044 0000a00d 00000000 2 22222222
R 82000048 0000a00e 00000000 2 33333333
W 82000040 00000000 000000ff 0 00000000
R 82000040 0000a00f 00000000 2 111111ff
R 82000043 0000a010 00000000 0 00000011
W 820000fc 00000000 a5a5a5a5 2 00000000
R 820000fe 0000a011 00000000 1 0000a5a5
R 820000fc 0000a012 00000000 2 a5a5a5a5
R 82000021 0000a013 00000000 0 00000056
R 82000023 0000a014 00000000 3 12345678

// ==== verilog.f ====
emesh_pkg.sv
emesh_word_ram.sv
emesh_ingress.sv
emesh_mem_stage.sv
emesh_mem_top.sv
tb_emesh_mem.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_emesh_mem
FILELIST  = verilog.f

SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) emesh_patterns.txt
	./$(BIN) | grep "All checks passed"

clean:
	rm -rf obj_dir
